/* hw/mrelbp_ci_pkg.sv */
`default_nettype none

package mrelbp_ci_pkg;

    // ========================================================================
    // Frame geometry
    // ========================================================================
    localparam int COLS   = 11;
    localparam int ROWS   = 11;
    localparam int RADIUS = 4;
    localparam int PIX_W  = 8;

    localparam int INNER_COUNT = (COLS - 2 * RADIUS) * (ROWS - 2 * RADIUS);
    localparam int SUM_W       = $clog2(INNER_COUNT * ((2 ** PIX_W) - 1) + 1);
    localparam int COL_W       = $clog2(COLS);
    localparam int ROW_W       = $clog2(ROWS);
    localparam int CENTER_COL  = COLS / 2;
    localparam int CENTER_ROW  = ROWS / 2;
    localparam int DIV_CNT_W   = $clog2(SUM_W);  // Divider step counter

    // ========================================================================
    // Stream payloads
    // ========================================================================
    typedef struct packed {
        logic [PIX_W-1:0] p0;  // Top left
        logic [PIX_W-1:0] p1;
        logic [PIX_W-1:0] p2;
        logic [PIX_W-1:0] p3;
        logic [PIX_W-1:0] p4;  // Window centre
        logic [PIX_W-1:0] p5;
        logic [PIX_W-1:0] p6;
        logic [PIX_W-1:0] p7;
        logic [PIX_W-1:0] p8;  // Bottom right
    } window_t;

    typedef struct packed {
        logic inner;   // At least RADIUS from every border
        logic center;
        logic last;    // Final position of the frame
    } pos_tag_t;

    typedef struct packed {
        pos_tag_t         tag;
        logic [PIX_W-1:0] median;
    } med_item_t;

    typedef struct packed {
        logic [SUM_W-1:0] sum;
        logic [PIX_W-1:0] center;
    } frame_res_t;

endpackage

`default_nettype wire

/* hw/pipe_reg.sv */
`default_nettype none

module pipe_reg #(
    parameter type T = logic [7:0]
) (
    input  logic clk,
    input  logic rst,
    input  logic valid_i,
    input  T     data_i,
    output logic valid_o,
    output T     data_o
);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    // Payload only moves with a valid beat
    always_ff @(posedge clk) begin
        if (valid_i) begin
            data_o <= data_i;
        end
    end

endmodule

`default_nettype wire

/* hw/ci_scan_ctrl.sv */
`default_nettype none

module ci_scan_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    win_valid_i,
    input  mrelbp_ci_pkg::window_t  win_i,
    output logic                    valid_o,
    output mrelbp_ci_pkg::window_t  win_o,
    output mrelbp_ci_pkg::pos_tag_t tag_o,
    output logic                    progress_done_o
);
    import mrelbp_ci_pkg::*;

    logic [COL_W-1:0] col_q;
    logic [ROW_W-1:0] row_q;
    logic             col_last;
    logic             row_last;
    logic             col_inner;
    logic             row_inner;
    pos_tag_t         tag_d;

    assign col_last = (col_q == COL_W'(COLS - 1));
    assign row_last = (row_q == ROW_W'(ROWS - 1));

    // Interior band on each axis
    assign col_inner = (col_q >= COL_W'(RADIUS)) &&
                       (col_q <= COL_W'(COLS - 1 - RADIUS));
    assign row_inner = (row_q >= ROW_W'(RADIUS)) &&
                       (row_q <= ROW_W'(ROWS - 1 - RADIUS));

    always_comb begin
        tag_d.inner  = col_inner & row_inner;
        tag_d.center = (col_q == COL_W'(CENTER_COL)) &&
                       (row_q == ROW_W'(CENTER_ROW));
        tag_d.last   = col_last & row_last;
    end

    // ========================================================================
    // Position counters, raster order
    // ========================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            col_q <= '0;
            row_q <= '0;
        end else if (win_valid_i) begin
            if (col_last) begin
                col_q <= '0;
                row_q <= row_last ? '0 : row_q + 1'b1;  // Wrap at frame end
            end else begin
                col_q <= col_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_o         <= 1'b0;
            progress_done_o <= 1'b0;
        end else begin
            valid_o         <= win_valid_i;
            progress_done_o <= win_valid_i & tag_d.last;
        end
    end

    always_ff @(posedge clk) begin
        if (win_valid_i) begin
            win_o <= win_i;
            tag_o <= tag_d;
        end
    end

endmodule

`default_nettype wire

/* hw/median9.sv */
`default_nettype none

module median9 (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     valid_i,
    input  mrelbp_ci_pkg::window_t   win_i,
    input  mrelbp_ci_pkg::pos_tag_t  tag_i,
    output logic                     valid_o,
    output mrelbp_ci_pkg::med_item_t item_o
);
    import mrelbp_ci_pkg::*;

    // Index 0 is the smallest of a trio
    typedef logic [2:0][PIX_W-1:0] trio_t;

    typedef struct packed {
        pos_tag_t        tag;
        logic [2:0][2:0][PIX_W-1:0] rows;  // Each row sorted
    } s1_t;

    typedef struct packed {
        pos_tag_t tag;
        trio_t    cand;  // Max of mins, median of mids, min of maxes
    } s2_t;

    function automatic trio_t sort3(input logic [PIX_W-1:0] a,
                                    input logic [PIX_W-1:0] b,
                                    input logic [PIX_W-1:0] c);
        logic [PIX_W-1:0] lo;
        logic [PIX_W-1:0] hi;
        trio_t            res;
        lo = (a < b) ? a : b;
        hi = (a < b) ? b : a;
        if (c < lo) begin
            res = {hi, lo, c};
        end else if (c > hi) begin
            res = {c, hi, lo};
        end else begin
            res = {hi, c, lo};
        end
        return res;
    endfunction

    s1_t       s1_d;
    s1_t       s1_q;
    s2_t       s2_d;
    s2_t       s2_q;
    med_item_t s3_d;
    logic      s1_valid;
    logic      s2_valid;
    trio_t     lows;
    trio_t     mids;
    trio_t     highs;
    trio_t     fin;

    // ========================================================================
    // Stage 1 sorts the three rows
    // ========================================================================
    always_comb begin
        s1_d.tag     = tag_i;
        s1_d.rows[0] = sort3(win_i.p0, win_i.p1, win_i.p2);
        s1_d.rows[1] = sort3(win_i.p3, win_i.p4, win_i.p5);
        s1_d.rows[2] = sort3(win_i.p6, win_i.p7, win_i.p8);
    end

    pipe_reg #(.T(s1_t)) u_s1 (
        .clk     (clk),
        .rst     (rst),
        .valid_i (valid_i),
        .data_i  (s1_d),
        .valid_o (s1_valid),
        .data_o  (s1_q)
    );

    // Stage 2 works column-wise on the sorted rows
    always_comb begin
        lows  = sort3(s1_q.rows[0][0], s1_q.rows[1][0], s1_q.rows[2][0]);
        mids  = sort3(s1_q.rows[0][1], s1_q.rows[1][1], s1_q.rows[2][1]);
        highs = sort3(s1_q.rows[0][2], s1_q.rows[1][2], s1_q.rows[2][2]);
        s2_d.tag  = s1_q.tag;
        s2_d.cand = {highs[0], mids[1], lows[2]};
    end

    pipe_reg #(.T(s2_t)) u_s2 (
        .clk     (clk),
        .rst     (rst),
        .valid_i (s1_valid),
        .data_i  (s2_d),
        .valid_o (s2_valid),
        .data_o  (s2_q)
    );

    always_comb begin
        fin         = sort3(s2_q.cand[0], s2_q.cand[1], s2_q.cand[2]);
        s3_d.tag    = s2_q.tag;
        s3_d.median = fin[1];  // Median of nine
    end

    pipe_reg #(.T(med_item_t)) u_s3 (
        .clk     (clk),
        .rst     (rst),
        .valid_i (s2_valid),
        .data_i  (s3_d),
        .valid_o (valid_o),
        .data_o  (item_o)
    );

endmodule

`default_nettype wire

/* hw/ci_accumulator.sv */
`default_nettype none

module ci_accumulator (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      valid_i,
    input  mrelbp_ci_pkg::med_item_t  item_i,
    output logic                      res_valid_o,
    output mrelbp_ci_pkg::frame_res_t res_o
);
    import mrelbp_ci_pkg::*;

    logic [SUM_W-1:0] sum_q;
    logic [SUM_W-1:0] sum_d;
    logic [PIX_W-1:0] center_q;

    // Border positions add nothing
    assign sum_d = sum_q + (item_i.tag.inner ? SUM_W'(item_i.median) : '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            sum_q       <= '0;
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= valid_i & item_i.tag.last;
            if (valid_i) begin
                sum_q <= item_i.tag.last ? '0 : sum_d;  // Restart for next frame
            end
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i && item_i.tag.center) begin
            center_q <= item_i.median;
        end
    end

    // ========================================================================
    // Frame result, includes the last item itself
    // ========================================================================
    always_ff @(posedge clk) begin
        if (valid_i && item_i.tag.last) begin
            res_o.sum    <= sum_d;
            res_o.center <= item_i.tag.center ? item_i.median : center_q;
        end
    end

endmodule

`default_nettype wire

/* hw/ci_mean_compare.sv */
`default_nettype none

module ci_mean_compare (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            res_valid_i,
    input  mrelbp_ci_pkg::frame_res_t       res_i,
    output logic                            ci_valid_o,
    output logic                            ci_o,
    output logic [mrelbp_ci_pkg::PIX_W-1:0] mean_q_o,
    output logic [mrelbp_ci_pkg::SUM_W-1:0] mean_r_o
);
    import mrelbp_ci_pkg::*;

    logic                 busy_q;
    logic [DIV_CNT_W-1:0] step_q;
    logic [SUM_W-1:0]     dividend_q;
    logic [SUM_W-1:0]     rem_q;
    logic [PIX_W-1:0]     quo_q;
    logic [PIX_W-1:0]     center_q;

    logic [SUM_W:0]       shifted;
    logic                 fits;
    logic [SUM_W-1:0]     rem_d;
    logic [PIX_W-1:0]     quo_d;
    logic                 ci_d;

    // ========================================================================
    // One restoring step per cycle, MSB of the dividend first
    // ========================================================================
    always_comb begin
        shifted = {rem_q, dividend_q[SUM_W-1]};
        fits    = (shifted >= (SUM_W + 1)'(INNER_COUNT));
        rem_d   = fits ? SUM_W'(shifted - (SUM_W + 1)'(INNER_COUNT))
                       : shifted[SUM_W-1:0];
        quo_d   = {quo_q[PIX_W-2:0], fits};
        // Centre not below the exact mean
        ci_d    = (center_q > quo_d) || ((center_q == quo_d) && (rem_d == '0));
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q     <= 1'b0;
            step_q     <= '0;
            ci_valid_o <= 1'b0;
            ci_o       <= 1'b0;
            mean_q_o   <= '0;
            mean_r_o   <= '0;
        end else begin
            ci_valid_o <= 1'b0;
            if (res_valid_i) begin
                busy_q <= 1'b1;
                step_q <= '0;
            end else if (busy_q) begin
                step_q <= step_q + 1'b1;
                if (step_q == DIV_CNT_W'(SUM_W - 1)) begin
                    busy_q     <= 1'b0;
                    ci_valid_o <= 1'b1;
                    ci_o       <= ci_d;
                    mean_q_o   <= quo_d;
                    mean_r_o   <= rem_d;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid_i) begin
            dividend_q <= res_i.sum;
            center_q   <= res_i.center;
            rem_q      <= '0;
            quo_q      <= '0;
        end else if (busy_q) begin
            dividend_q <= {dividend_q[SUM_W-2:0], 1'b0};
            rem_q      <= rem_d;
            quo_q      <= quo_d;
        end
    end

endmodule

`default_nettype wire

/* hw/mrelbp_ci_r4.sv */
`default_nettype none

module mrelbp_ci_r4 (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            win_valid_i,
    input  mrelbp_ci_pkg::window_t          win_i,
    output logic                            progress_done_o,
    output logic                            ci_valid_o,
    output logic                            ci_o,
    output logic [mrelbp_ci_pkg::PIX_W-1:0] mean_q_o,
    output logic [mrelbp_ci_pkg::SUM_W-1:0] mean_r_o
);
    import mrelbp_ci_pkg::*;

    logic       scan_valid;
    window_t    scan_win;
    pos_tag_t   scan_tag;
    logic       med_valid;
    med_item_t  med_item;
    logic       res_valid;
    frame_res_t res;

    // ========================================================================
    // Tag, median, accumulate, divide and compare
    // ========================================================================
    ci_scan_ctrl u_scan (
        .clk             (clk),
        .rst             (rst),
        .win_valid_i     (win_valid_i),
        .win_i           (win_i),
        .valid_o         (scan_valid),
        .win_o           (scan_win),
        .tag_o           (scan_tag),
        .progress_done_o (progress_done_o)
    );

    median9 u_median (
        .clk     (clk),
        .rst     (rst),
        .valid_i (scan_valid),
        .win_i   (scan_win),
        .tag_i   (scan_tag),
        .valid_o (med_valid),
        .item_o  (med_item)
    );

    ci_accumulator u_acc (
        .clk         (clk),
        .rst         (rst),
        .valid_i     (med_valid),
        .item_i      (med_item),
        .res_valid_o (res_valid),
        .res_o       (res)
    );

    ci_mean_compare u_mean (
        .clk         (clk),
        .rst         (rst),
        .res_valid_i (res_valid),
        .res_i       (res),
        .ci_valid_o  (ci_valid_o),
        .ci_o        (ci_o),
        .mean_q_o    (mean_q_o),
        .mean_r_o    (mean_r_o)
    );

endmodule

`default_nettype wire

/* bench/tb_clkgen.sv */
`default_nettype none

module tb_clkgen (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        rst_o = 1'b1;
        repeat (4) @(posedge clk_o);
        rst_o <= 1'b0;  // Released on a rising edge, synchronous to the DUT
    end

    always #5 clk_o = ~clk_o;

endmodule

`default_nettype wire

/* bench/mrelbp_ci_assert.sv */
`default_nettype none

module mrelbp_ci_assert (
    input logic clk,
    input logic rst,
    input logic progress_done_i,
    input logic ci_valid_i,
    input logic res_valid_i,
    input logic div_busy_i
);
    import mrelbp_ci_pkg::*;

    int fail_cnt = 0;

    // ========================================================================
    // Frame-end pulses and divider occupancy
    // ========================================================================
    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        res_valid_i |-> !div_busy_i)
        else begin
            $error("Frame result arrived while divider busy");
            fail_cnt++;
        end

    a_done_single: assert property (@(posedge clk) disable iff (rst)
        progress_done_i |=> !progress_done_i)
        else begin
            $error("progress_done_o wider than one cycle");
            fail_cnt++;
        end

    // Every frame end yields a result
    a_done_result: assert property (@(posedge clk) disable iff (rst)
        progress_done_i |-> ##(SUM_W + 5) ci_valid_i)
        else begin
            $error("progress_done_o not followed by ci_valid_o");
            fail_cnt++;
        end

    // Fixed lag from frame end to result
    a_ci_lag: assert property (@(posedge clk) disable iff (rst)
        ci_valid_i |-> $past(progress_done_i, SUM_W + 5))
        else begin
            $error("ci_valid_o off its fixed lag");
            fail_cnt++;
        end

endmodule

bind mrelbp_ci_r4 mrelbp_ci_assert assert0 (
    .clk             (clk),
    .rst             (rst),
    .progress_done_i (progress_done_o),
    .ci_valid_i      (ci_valid_o),
    .res_valid_i     (res_valid),
    .div_busy_i      (u_mean.busy_q)
);

`default_nettype wire

/* bench/mrelbp_ci_tb.sv */
`default_nettype none

module mrelbp_ci_tb;
    import mrelbp_ci_pkg::*;

    localparam int FRAME_LEN    = COLS * ROWS;
    localparam int TOTAL_FRAMES = 12;
    localparam int CYCLE_LIMIT  = TOTAL_FRAMES * (2 * FRAME_LEN + 4) + SUM_W + 200;

    typedef enum int {M_RANDOM, M_GAPS, M_TIE, M_CENTER_LOW, M_BORDER} mode_t;

    typedef struct packed {
        logic [PIX_W-1:0] q;
        logic [SUM_W-1:0] r;
        logic             ci;
    } expect_t;

    logic             clk;
    logic             rst;
    logic             win_valid_i;
    window_t          win_i;
    logic             progress_done_o;
    logic             ci_valid_o;
    logic             ci_o;
    logic [PIX_W-1:0] mean_q_o;
    logic [SUM_W-1:0] mean_r_o;

    integer  seed = 32'hf661_ee96;
    int      cyc = 0;
    int      errors = 0;
    int      strobes = 0;
    int      done_seen = 0;
    int      ci_seen = 0;
    int      tests_failed = 0;
    int      done_at[$];  // Expected pulse cycles
    int      ci_at[$];
    expect_t exp_q[$];

    tb_clkgen clkgen0 (.clk_o(clk), .rst_o(rst));

    mrelbp_ci_r4 dut0 (
        .clk             (clk),
        .rst             (rst),
        .win_valid_i     (win_valid_i),
        .win_i           (win_i),
        .progress_done_o (progress_done_o),
        .ci_valid_o      (ci_valid_o),
        .ci_o            (ci_o),
        .mean_q_o        (mean_q_o),
        .mean_r_o        (mean_r_o)
    );

    // ========================================================================
    // Reference model
    // ========================================================================
    function automatic logic is_inner(input int c, input int r);
        return (c >= RADIUS) && (c <= COLS - 1 - RADIUS) &&
               (r >= RADIUS) && (r <= ROWS - 1 - RADIUS);
    endfunction

    function automatic int median_by_sort(input window_t w);
        logic [9*PIX_W-1:0] flat;
        int                 v[9];
        int                 t;
        int                 i;
        int                 j;
        flat = w;
        for (i = 0; i < 9; i++) v[i] = flat[i*PIX_W +: PIX_W];
        for (i = 0; i < 8; i++) begin
            for (j = 0; j < 8 - i; j++) begin
                if (v[j] > v[j+1]) begin
                    t      = v[j];
                    v[j]   = v[j+1];
                    v[j+1] = t;
                end
            end
        end
        return v[4];
    endfunction

    function automatic window_t make_window(input mode_t mode, input int c, input int r,
                                            input logic [PIX_W-1:0] level);
        logic [9*PIX_W-1:0] flat;
        int                 i;
        for (i = 0; i < 9; i++) begin
            case (mode)
                M_TIE:    flat[i*PIX_W +: PIX_W] = level;
                M_BORDER: flat[i*PIX_W +: PIX_W] = is_inner(c, r) ?
                              PIX_W'($random(seed) & 15) :  // Small interior values
                              ((($random(seed) & 1) != 0) ? {PIX_W{1'b1}} : {PIX_W{1'b0}});
                default:  flat[i*PIX_W +: PIX_W] = PIX_W'($random(seed));
            endcase
        end
        if (mode == M_CENTER_LOW && c == CENTER_COL && r == CENTER_ROW) flat = '0;
        return window_t'(flat);
    endfunction

    task automatic send_frame(input mode_t mode);
        window_t          w;
        logic [PIX_W-1:0] level;
        int               sum;
        int               center;
        int               med;
        expect_t          e;
        sum    = 0;
        center = 0;
        level  = PIX_W'($random(seed));
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                w   = make_window(mode, c, r, level);
                med = median_by_sort(w);
                if (is_inner(c, r)) sum += med;
                if (c == CENTER_COL && r == CENTER_ROW) center = med;
                if (mode == M_GAPS && ($random(seed) & 1) != 0) begin
                    @(posedge clk);
                    win_valid_i <= 1'b0;
                end
                @(posedge clk);
                win_valid_i <= 1'b1;
                win_i       <= w;
            end
        end
        e.q  = PIX_W'(sum / INNER_COUNT);
        e.r  = SUM_W'(sum % INNER_COUNT);
        e.ci = (center * INNER_COUNT >= sum);  // Centre not below the exact mean
        exp_q.push_back(e);
    endtask

    task automatic run_test(input int num, input string name, input mode_t mode,
                            input int frames);
        int err0;
        err0 = errors;
        repeat (frames) send_frame(mode);
        @(posedge clk);
        win_valid_i <= 1'b0;
        while (exp_q.size() != 0 || done_at.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
        if (errors == err0) begin
            $display("Test %0d %s: PASS", num, name);
        end else begin
            $display("Test %0d %s: FAIL with %0d errors", num, name, errors - err0);
            tests_failed++;
        end
    endtask

    // ========================================================================
    // Output monitor, sampled on the falling edge
    // ========================================================================
    task automatic check_result();
        expect_t e;
        int      t;
        ci_seen++;
        if (exp_q.size() == 0 || ci_at.size() == 0) begin
            $display("Unexpected ci_valid_o pulse with no frame pending at time %0t", $time);
            errors++;
        end else begin
            e = exp_q.pop_front();
            t = ci_at.pop_front();
            assert (cyc == t) else begin
                $display("Mismatch at %0t: ci_valid_o in cycle %0d, expected %0d", $time, cyc, t);
                errors++;
            end
            assert (mean_q_o == e.q) else begin
                $display("Mismatch at %0t: mean_q_o %0d, expected %0d", $time, mean_q_o, e.q);
                errors++;
            end
            assert (mean_r_o == e.r) else begin
                $display("Mismatch at %0t: mean_r_o %0d, expected %0d", $time, mean_r_o, e.r);
                errors++;
            end
            assert (ci_o == e.ci) else begin
                $display("Mismatch at %0t: ci_o %0b, expected %0b", $time, ci_o, e.ci);
                errors++;
            end
        end
    endtask

    always @(negedge clk) begin
        if (rst) begin
            assert (!progress_done_o && !ci_valid_o) else begin
                $display("Mismatch at %0t: pulse output high during reset", $time);
                errors++;
            end
        end else begin
            if (progress_done_o) begin
                done_seen++;
                if (done_at.size() == 0) begin
                    $display("Unexpected progress_done_o pulse at time %0t", $time);
                    errors++;
                end else begin
                    assert (cyc == done_at[0]) else begin
                        $display("Mismatch at %0t: progress_done_o in cycle %0d, expected %0d",
                                 $time, cyc, done_at[0]);
                        errors++;
                    end
                    void'(done_at.pop_front());
                end
            end
            if (ci_valid_o) check_result();
            if (win_valid_i) begin
                strobes++;
                if (strobes % FRAME_LEN == 0) begin  // Last window of a frame
                    done_at.push_back(cyc + 1);
                    ci_at.push_back(cyc + SUM_W + 6);
                end
            end
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        win_valid_i = 1'b0;
        win_i       = '0;
        @(negedge rst);
        run_test(1, "back_to_back", M_RANDOM, 3);
        run_test(2, "random_gaps", M_GAPS, 3);
        run_test(3, "tie", M_TIE, 2);
        run_test(4, "centre_low", M_CENTER_LOW, 2);
        run_test(5, "border_exclusion", M_BORDER, 2);
        assert (done_seen == TOTAL_FRAMES && ci_seen == TOTAL_FRAMES) else begin
            $display("Pulse count wrong: %0d progress_done_o and %0d ci_valid_o for %0d frames",
                     done_seen, ci_seen, TOTAL_FRAMES);
            errors++;
        end
        errors += dut0.assert0.fail_cnt;
        $display("Tests run: 5, failed: %0d, frames: %0d, errors: %0d",
                 tests_failed, ci_seen, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
hw/mrelbp_ci_pkg.sv
hw/pipe_reg.sv
hw/ci_scan_ctrl.sv
hw/median9.sv
hw/ci_accumulator.sv
hw/ci_mean_compare.sv
hw/mrelbp_ci_r4.sv
bench/tb_clkgen.sv
bench/mrelbp_ci_assert.sv
bench/mrelbp_ci_tb.sv

/* Bender.yml */
package:
  name: mrelbp_ci

sources:
  - hw/mrelbp_ci_pkg.sv
  - hw/pipe_reg.sv
  - hw/ci_scan_ctrl.sv
  - hw/median9.sv
  - hw/ci_accumulator.sv
  - hw/ci_mean_compare.sv
  - hw/mrelbp_ci_r4.sv
  - target: test
    files:
      - bench/tb_clkgen.sv
      - bench/mrelbp_ci_assert.sv
      - bench/mrelbp_ci_tb.sv
